// ==== rtl/branch_eval.sv ====
/*
  short-branch condition evaluator, purely combinational
  taken is meaningful for opcodes 0x20..0x2F and low for all others
  no registers, cen has no effect here
*/
`default_nettype none

module branch_eval (
    input  wire cpu_isa_pkg::byte_t op,
    input  wire cpu_isa_pkg::cc_t   cc,
    output logic                    taken
);

    import cpu_isa_pkg::*;

    logic c;
    logic v;
    logic z;
    logic n;
    // signed less-than
    logic lt;
    // condition for the even opcode of each pair
    logic base;

    assign c  = cc[CC_C];
    assign v  = cc[CC_V];
    assign z  = cc[CC_Z];
    assign n  = cc[CC_N];
    assign lt = n ^ v;

    // opcodes come in pairs, the odd one tests the inverse
    always_comb begin
        case (op[3:1])
            // bra / brn
            3'd0: base = 1'b1;
            // bhi / bls
            3'd1: base = ~(c | z);
            // bcc / bcs
            3'd2: base = ~c;
            // bne / beq
            3'd3: base = ~z;
            // bvc / bvs
            3'd4: base = ~v;
            // bpl / bmi
            3'd5: base = ~n;
            // bge / blt
            3'd6: base = ~lt;
            // bgt / ble
            default: base = ~(z | lt);
        endcase
    end

    // odd opcode flips the sense, non-branches never take
    assign taken = (classify_op(op) == OP_BRANCH) && (base ^ op[0]);

endmodule

`default_nettype wire

// ==== rtl/cpu_isa_pkg.sv ====
/*
  instruction-set types of the 6809-style core
  opcode ranges cover short branches and PSHS/PULS/PSHU/PULU only
  stacked register order follows the postbyte mask, bit 0 = CC
*/
`default_nettype none

`include "ctrl_params.svh"

package cpu_isa_pkg;

    typedef logic [`CTRL_ADDR_W-1:0] addr_t;
    typedef logic [`CTRL_DATA_W-1:0] byte_t;
    typedef logic [`CTRL_DATA_W-1:0] cc_t;

    // condition-code bit positions
    localparam int CC_C = 0;
    localparam int CC_V = 1;
    localparam int CC_Z = 2;
    localparam int CC_N = 3;

    typedef enum logic [1:0] {
        OP_OTHER,
        OP_BRANCH,
        OP_STACK
    } op_class_t;

    // short branches, low nibble picks the condition
    localparam byte_t OP_BRANCH_LO = 8'h20;
    localparam byte_t OP_BRANCH_HI = 8'h2F;
    // pshs, puls, pshu, pulu
    localparam byte_t OP_STACK_LO  = 8'h34;
    localparam byte_t OP_STACK_HI  = 8'h37;
    // opcode bits inside the stack group
    localparam int OP_PULL_BIT = 0;
    localparam int OP_USTK_BIT = 1;

    // one value per postbyte mask bit
    // SU is the other stack pointer (U for pshs/puls, S for pshu/pulu)
    typedef enum logic [2:0] {
        CC, A, B, DP, X, Y, SU, PC
    } stk_reg_t;

    function automatic op_class_t classify_op(byte_t op);
        if (op >= OP_BRANCH_LO && op <= OP_BRANCH_HI) return OP_BRANCH;
        if (op >= OP_STACK_LO && op <= OP_STACK_HI) return OP_STACK;
        return OP_OTHER;
    endfunction

    // X and above are 16-bit registers
    function automatic logic reg_is_wide(stk_reg_t r);
        return r >= X;
    endfunction

endpackage

`default_nettype wire

// ==== rtl/ctrl_params.svh ====
/*
  widths and instruction lengths for the control slice
  only short branches and single-postbyte stack ops are covered
  every opcode outside those two groups counts as one byte
*/
`ifndef CTRL_PARAMS_SVH
`define CTRL_PARAMS_SVH

`define CTRL_ADDR_W      16
`define CTRL_DATA_W      8
// opcode plus offset byte
`define CTRL_LEN_BRANCH  2
// opcode plus register mask
`define CTRL_LEN_STACK   2
`define CTRL_NUM_REGS    8

`endif

// ==== rtl/ctrl_pkg.sv ====
/*
  control-path types shared by the sequencer and the pc unit
  a step only names the transfer, no data moves through this slice
*/
`default_nettype none

package ctrl_pkg;

    // one byte transfer to or from a stack
    typedef struct packed {
        // high only in cycles that carry a transfer
        logic                  valid;
        cpu_isa_pkg::stk_reg_t reg_sel;
        // upper byte of a 16-bit register
        logic                  hi_byte;
        // 1 for push, 0 for pull
        logic                  write;
        // U stack instead of S
        logic                  use_u;
    } stack_step_t;

    // sequencer phase, HI and LO name the byte of the current register
    typedef enum logic [1:0] {
        IDLE,
        HI,
        LO
    } seq_state_t;

    // start command from the pc unit
    // start holds until the next enabled clock
    typedef struct packed {
        logic               start;
        logic               pull;
        logic               use_u;
        // postbyte register mask
        cpu_isa_pkg::byte_t mask;
    } stack_cmd_t;

endpackage

`default_nettype wire

// ==== rtl/ctrl_top.sv ====
/*
  control slice top level
  op_valid must stay high until the instruction is accepted
  cen low freezes the slice and masks step.valid
*/
`default_nettype none

module ctrl_top (
    input  wire                   clk,
    input  wire                   rst,
    input  wire                   cen,
    input  wire                   halt,
    input  wire                   op_valid,
    input  wire cpu_isa_pkg::byte_t op,
    input  wire cpu_isa_pkg::byte_t postbyte,
    input  wire cpu_isa_pkg::cc_t   cc,
    output logic                  ready,
    output ctrl_pkg::stack_step_t step,
    output cpu_isa_pkg::addr_t    pc
);

    import ctrl_pkg::*;

    logic       taken;
    logic       seq_busy;
    stack_cmd_t cmd;

    // branch condition straight from the current cc
    branch_eval u_branch (
        .op         ( op         ),
        .cc         ( cc         ),
        .taken      ( taken      )
    );

    pc_update u_pc (
        .clk        ( clk        ),
        .rst        ( rst        ),
        .cen        ( cen        ),
        .halt       ( halt       ),
        .op_valid   ( op_valid   ),
        .op         ( op         ),
        .postbyte   ( postbyte   ),
        .taken      ( taken      ),
        .seq_busy   ( seq_busy   ),
        .ready      ( ready      ),
        .cmd        ( cmd        ),
        .pc         ( pc         )
    );

    stack_seq u_stack (
        .clk        ( clk        ),
        .rst        ( rst        ),
        .cen        ( cen        ),
        .cmd        ( cmd        ),
        .busy       ( seq_busy   ),
        .step       ( step       )
    );

endmodule

`default_nettype wire

// ==== rtl/pc_update.sv ====
/*
  instruction acceptance and program counter
  pc moves on the clock of acceptance, wrap-around is modulo 2^16
  a stack op blocks further issue until the sequencer is idle again
  pulled PC bytes do not load pc here
*/
`default_nettype none

`include "ctrl_params.svh"

module pc_update (
    input  wire                  clk,
    input  wire                  rst,
    input  wire                  cen,
    input  wire                  halt,
    input  wire                  op_valid,
    input  wire cpu_isa_pkg::byte_t op,
    input  wire cpu_isa_pkg::byte_t postbyte,
    input  wire                  taken,
    input  wire                  seq_busy,
    output logic                 ready,
    output ctrl_pkg::stack_cmd_t cmd,
    output cpu_isa_pkg::addr_t   pc
);

    import cpu_isa_pkg::*;

    op_class_t cls;
    logic      accept;
    addr_t     offset;
    addr_t     pc_next;

    logic      start_q;
    logic      pull_q;
    logic      use_u_q;
    byte_t     mask_q;

    assign cls = classify_op(op);

    // a pending start also blocks issue, busy only rises one clock later
    assign ready  = !seq_busy && !halt && !start_q;
    assign accept = cen && op_valid && ready;

    // branch offset, sign-extended postbyte
    assign offset = {{(`CTRL_ADDR_W - `CTRL_DATA_W){postbyte[`CTRL_DATA_W-1]}}, postbyte};

    // offset is relative to the byte after the branch
    always_comb begin
        case (cls)
            OP_BRANCH: pc_next = pc + addr_t'(`CTRL_LEN_BRANCH) + (taken ? offset : '0);
            OP_STACK:  pc_next = pc + addr_t'(`CTRL_LEN_STACK);
            default:   pc_next = pc + addr_t'(1);
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc      <= '0;
            start_q <= 1'b0;
        end else if (cen) begin
            if (accept) pc <= pc_next;
            // start lasts until the next enabled clock
            start_q <= accept && (cls == OP_STACK);
        end
    end

    // direction, stack select and mask for the sequencer
    always_ff @(posedge clk) begin
        if (accept && cls == OP_STACK) begin
            pull_q  <= op[OP_PULL_BIT];
            use_u_q <= op[OP_USTK_BIT];
            mask_q  <= postbyte;
        end
    end

    assign cmd = '{start: start_q, pull: pull_q, use_u: use_u_q, mask: mask_q};

endmodule

`default_nettype wire

// ==== rtl/stack_seq.sv ====
/*
  push/pull sequencer, one byte transfer per enabled clock
  push walks mask bits 7..0 low byte first, pull walks 0..7 high byte first
  an empty mask keeps busy for one enabled cycle and issues no step
  the command is only taken while idle
*/
`default_nettype none

`include "ctrl_params.svh"

module stack_seq (
    input  wire                  clk,
    input  wire                  rst,
    input  wire                  cen,
    input  wire ctrl_pkg::stack_cmd_t cmd,
    output logic                 busy,
    output ctrl_pkg::stack_step_t step
);

    import cpu_isa_pkg::*;
    import ctrl_pkg::*;

    seq_state_t state_q;
    // registers still to be transferred
    byte_t      mask_q;
    logic       pull_q;
    logic       use_u_q;

    stk_reg_t   pick;
    logic       wide;
    seq_state_t first_ph;
    seq_state_t second_ph;
    logic       last_byte;
    byte_t      mask_next;

    // next register, highest bit on push, lowest on pull
    always_comb begin
        pick = CC;
        if (pull_q) begin
            for (int i = `CTRL_NUM_REGS - 1; i >= 0; i--) begin
                if (mask_q[i]) pick = stk_reg_t'(i[2:0]);
            end
        end else begin
            for (int i = 0; i < `CTRL_NUM_REGS; i++) begin
                if (mask_q[i]) pick = stk_reg_t'(i[2:0]);
            end
        end
    end

    assign wide = reg_is_wide(pick);

    // byte order inside a 16-bit register
    assign first_ph  = pull_q ? HI : LO;
    assign second_ph = pull_q ? LO : HI;

    // 8-bit registers finish in one step
    assign last_byte = !wide || (state_q == second_ph);
    assign mask_next = last_byte ? (mask_q & ~(byte_t'(1) << pick)) : mask_q;

    assign busy = (state_q != IDLE);

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= IDLE;
        end else if (cen) begin
            if (state_q == IDLE) begin
                if (cmd.start) state_q <= cmd.pull ? HI : LO;
            end else if (mask_next == '0) begin
                // drop busy on the clock of the last step
                state_q <= IDLE;
            end else if (last_byte) begin
                state_q <= first_ph;
            end else begin
                state_q <= second_ph;
            end
        end
    end

    // command payload and remaining mask
    always_ff @(posedge clk) begin
        if (cen) begin
            if (state_q == IDLE) begin
                if (cmd.start) begin
                    mask_q  <= cmd.mask;
                    pull_q  <= cmd.pull;
                    use_u_q <= cmd.use_u;
                end
            end else begin
                mask_q <= mask_next;
            end
        end
    end

    // step is only valid in enabled cycles with work left
    always_comb begin
        step.valid   = cen && busy && (mask_q != '0);
        step.reg_sel = pick;
        // 8-bit registers always report the low byte
        step.hi_byte = wide && (state_q == HI);
        step.write   = !pull_q;
        step.use_u   = use_u_q;
    end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# builds tb_ctrl with Verilator and runs it into sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_ctrl -f src.f -o sim_tb_ctrl \
    || { echo "build failed"; exit 1; }
./obj_dir/sim_tb_ctrl > sim.log 2>&1 || echo "simulator exited with an error" >> sim.log
cat sim.log
grep -q "TB FAILED" sim.log && { echo "result fail"; exit 1; }
grep -q "TB PASSED" sim.log || { echo "result fail, no pass line"; exit 1; }
echo "result pass"
exit 0

// ==== src.f ====
+incdir+rtl
rtl/cpu_isa_pkg.sv
rtl/ctrl_pkg.sv
rtl/branch_eval.sv
rtl/stack_seq.sv
rtl/pc_update.sv
rtl/ctrl_top.sv
tests/tb_ctrl.sv

// ==== tests/tb_ctrl.sv ====
/*
  random-stimulus testbench for ctrl_top
  a cycle model predicts ready, pc and the stack steps
  inputs move 5 ns after the rising edge, outputs are checked at the falling edge
  the run stops at the first mismatch
*/
`default_nettype none

`include "ctrl_params.svh"

module tb_ctrl;

    timeunit 1ns;
    timeprecision 1ps;

    import cpu_isa_pkg::*;
    import ctrl_pkg::*;

    localparam int NUM_OPS    = 400;
    localparam int MAX_CYCLES = NUM_OPS * 40;

    logic        clk;
    logic        rst;
    logic        cen;
    logic        halt;
    logic        op_valid;
    byte_t       op;
    byte_t       postbyte;
    cc_t         cc;
    logic        ready;
    stack_step_t step;
    addr_t       pc;

    // model of the program counter and the sequencer
    addr_t       pc_m;
    // start command waiting for the sequencer
    logic        pend_m;
    // enabled cycles that busy still stays high
    int          busy_left;
    int          steps_next;
    stack_step_t step_q[$];
    logic [15:0] cond_seen;
    // stimulus bookkeeping
    logic        took_op;
    int          issued;
    int          halt_left;
    int          cycles;

    ctrl_top UUT (
        .clk      ( clk      ),
        .rst      ( rst      ),
        .cen      ( cen      ),
        .halt     ( halt     ),
        .op_valid ( op_valid ),
        .op       ( op       ),
        .postbyte ( postbyte ),
        .cc       ( cc       ),
        .ready    ( ready    ),
        .step     ( step     ),
        .pc       ( pc       )
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) abort_run("timeout, the run did not finish in time");
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] exp_v,
                                   input logic [31:0] act_v);
        $display("[FAIL] t=%0t %s expected 0x%0h actual 0x%0h", $time, name, exp_v, act_v);
        $display("TB FAILED");
        $fatal(1, "mismatch on %s", name);
    endtask

    // 6809 short-branch conditions in opcode order
    function automatic logic branch_cond(input logic [3:0] sel, input cc_t f);
        logic c;
        logic v;
        logic z;
        logic n;
        logic res;
        c = f[0];
        v = f[1];
        z = f[2];
        n = f[3];
        case (sel)
            4'h0: res = 1'b1;
            4'h1: res = 1'b0;
            4'h2: res = !(c || z);
            4'h3: res = c || z;
            4'h4: res = !c;
            4'h5: res = c;
            4'h6: res = !z;
            4'h7: res = z;
            4'h8: res = !v;
            4'h9: res = v;
            4'hA: res = !n;
            4'hB: res = n;
            4'hC: res = (n == v);
            4'hD: res = (n != v);
            4'hE: res = !z && (n == v);
            default: res = z || (n != v);
        endcase
        return res;
    endfunction

    function automatic byte_t pick_other_op();
        byte_t o;
        o = byte_t'($urandom);
        while ((o >= OP_BRANCH_LO && o <= OP_BRANCH_HI) || (o >= OP_STACK_LO && o <= OP_STACK_HI))
            o = byte_t'($urandom);
        return o;
    endfunction

    // expected transfers of one push or pull
    task automatic queue_steps(input byte_t sop, input byte_t mask, output int count);
        stack_step_t s;
        int b;
        count = 0;
        s.valid = 1'b1;
        s.write = !sop[0];
        s.use_u = sop[1];
        s.hi_byte = 1'b0;
        s.reg_sel = CC;
        for (int k = 0; k < 8; k++) begin
            // pull walks up from bit 0, push down from bit 7
            b = sop[0] ? k : 7 - k;
            if (mask[b]) begin
                s.reg_sel = stk_reg_t'(b[2:0]);
                if (b >= 4) begin
                    // pull sends the high byte first, push the low byte
                    s.hi_byte = sop[0];
                    step_q.push_back(s);
                    s.hi_byte = !sop[0];
                    step_q.push_back(s);
                    count += 2;
                end else begin
                    s.hi_byte = 1'b0;
                    step_q.push_back(s);
                    count += 1;
                end
            end
        end
    endtask

    task automatic drive_inputs();
        int r;
        cc  = cc_t'($urandom);
        cen = ($urandom % 100) >= 20;
        // halt comes in short bursts
        if (halt_left > 0) begin
            halt = 1'b1;
            halt_left--;
        end else if (($urandom % 100) < 4) begin
            halt = 1'b1;
            halt_left = int'($urandom % 4);
        end else begin
            halt = 1'b0;
        end
        if (took_op) begin
            op_valid = 1'b0;
            took_op = 1'b0;
        end
        if (!op_valid && issued < NUM_OPS) begin
            r = int'($urandom % 100);
            if (r < 40) begin
                op = OP_BRANCH_LO + byte_t'($urandom % 16);
                postbyte = byte_t'($urandom);
            end else if (r < 70) begin
                op = OP_STACK_LO + byte_t'($urandom % 4);
                postbyte = (($urandom % 8) == 0) ? 8'h00 : byte_t'($urandom);
            end else begin
                op = pick_other_op();
                postbyte = byte_t'($urandom);
            end
            op_valid = 1'b1;
            issued++;
        end
    endtask

    // compare outputs, then advance the model over the coming edge
    task automatic check_cycle();
        stack_step_t exp_s;
        logic ready_m;
        logic valid_m;
        logic accept;
        int n;
        ready_m = !halt && !pend_m && (busy_left == 0);
        valid_m = cen && (busy_left > 0) && (step_q.size() > 0);
        assert (pc == pc_m) else report_mismatch("pc", 32'(pc_m), 32'(pc));
        assert (ready == ready_m) else report_mismatch("ready", 32'(ready_m), 32'(ready));
        assert (step.valid == valid_m)
            else report_mismatch("step.valid", 32'(valid_m), 32'(step.valid));
        if (valid_m) begin
            exp_s = step_q.pop_front();
            assert (step == exp_s) else report_mismatch("step", 32'(exp_s), 32'(step));
        end
        accept = cen && op_valid && ready_m;
        if (cen) begin
            if (busy_left > 0) busy_left--;
            // an empty mask still keeps busy for one cycle
            if (pend_m) begin
                busy_left = (steps_next == 0) ? 1 : steps_next;
                pend_m = 1'b0;
            end
        end
        if (accept) begin
            took_op = 1'b1;
            if (op >= OP_BRANCH_LO && op <= OP_BRANCH_HI) begin
                cond_seen[op[3:0]] = 1'b1;
                pc_m = pc_m + addr_t'(`CTRL_LEN_BRANCH);
                if (branch_cond(op[3:0], cc)) pc_m = pc_m + {{8{postbyte[7]}}, postbyte};
            end else if (op >= OP_STACK_LO && op <= OP_STACK_HI) begin
                pc_m = pc_m + addr_t'(`CTRL_LEN_STACK);
                queue_steps(op, postbyte, n);
                steps_next = n;
                pend_m = 1'b1;
            end else begin
                pc_m = pc_m + addr_t'(1);
            end
        end
    endtask

    initial begin
        void'($urandom(74143));
        clk = 1'b0;
        rst = 1'b1;
        cen = 1'b1;
        halt = 1'b0;
        op_valid = 1'b0;
        op = '0;
        postbyte = '0;
        cc = '0;
        pc_m = '0;
        pend_m = 1'b0;
        busy_left = 0;
        steps_next = 0;
        cond_seen = '0;
        took_op = 1'b0;
        issued = 0;
        halt_left = 0;
        cycles = 0;
        repeat (10) @(posedge clk);
        #5 rst = 1'b0;
        @(negedge clk);
        assert (pc == '0) else report_mismatch("pc", 32'h0, 32'(pc));
        assert (!step.valid) else report_mismatch("step.valid", 32'h0, 32'(step.valid));
        assert (ready) else report_mismatch("ready", 32'h1, 32'(ready));
        while (issued < NUM_OPS || op_valid || took_op || pend_m || busy_left > 0
               || step_q.size() > 0) begin
            @(posedge clk);
            #5;
            drive_inputs();
            @(negedge clk);
            check_cycle();
        end
        if (cond_seen != 16'hFFFF) begin
            abort_run("not every branch condition was exercised");
        end else begin
            $display("TB PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire
